//--- banked_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module banked_ram (
  input  wire logic                   clk,
  input  wire logic                   resetn,
  input  wire logic                   ram_valid,
  input  wire logic [`SOC_ADDR_W-1:0] req_addr,
  input  wire logic [`SOC_DATA_W-1:0] req_wdata,
  input  wire logic [`SOC_STRB_W-1:0] req_wstrb,
  output logic                        ram_ready,
  output logic [`SOC_DATA_W-1:0]      ram_rdata
);
  import soc_mem_pkg::*;

  localparam int BANK_W = `SOC_BANK_SEL_HI - `SOC_BANK_SEL_LO + 1;
  localparam int WORD_W = $clog2(`SOC_BANK_WORDS);

  ram_state_e             state;
  logic                   valid_q;
  logic                   start;
  logic [BANK_W-1:0]      bank_q;
  // bank whose output is in bank_dout this cycle
  logic [BANK_W-1:0]      bank_sel_q;
  logic [WORD_W-1:0]      word_q;
  logic [`SOC_DATA_W-1:0] wdata_q;
  logic [`SOC_STRB_W-1:0] bank_wstrb [`SOC_RAM_BANKS];
  logic [`SOC_DATA_W-1:0] bank_dout [`SOC_RAM_BANKS];

  // an access begins only on the rising edge of ram_valid
  assign start = ram_valid && !valid_q;

  always_ff @(posedge clk) begin
    if (start) begin
      bank_q  <= req_addr[`SOC_BANK_SEL_HI:`SOC_BANK_SEL_LO];
      word_q  <= req_addr[`SOC_BANK_SEL_LO-1:2];
      wdata_q <= req_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= RAM_IDLE;
      valid_q   <= 1'b0;
      ram_ready <= 1'b0;
      for (int b = 0; b < `SOC_RAM_BANKS; b++) begin
        bank_wstrb[b] <= '0;
      end
    end else begin
      valid_q   <= ram_valid;
      ram_ready <= 1'b0;

      // strobes only reach the addressed bank, for one cycle
      for (int b = 0; b < `SOC_RAM_BANKS; b++) begin
        if (start && (req_addr[`SOC_BANK_SEL_HI:`SOC_BANK_SEL_LO] == BANK_W'(b))) begin
          bank_wstrb[b] <= req_wstrb;
        end else begin
          bank_wstrb[b] <= '0;
        end
      end

      case (state)
        RAM_IDLE: begin
          if (start) begin
            state <= (|req_wstrb) ? RAM_WRITE : RAM_READ;
          end
        end
        // bank write happens on this edge
        RAM_WRITE: begin
          ram_ready <= 1'b1;
          state     <= RAM_IDLE;
        end
        RAM_READ: begin
          state <= RAM_DONE;
        end
        // output register loads on this edge
        RAM_DONE: begin
          ram_ready <= 1'b1;
          state     <= RAM_IDLE;
        end
        default: begin
          state <= RAM_IDLE;
        end
      endcase
    end
  end

  for (genvar g = 0; g < `SOC_RAM_BANKS; g++) begin : g_bank
    logic [`SOC_STRB_W-1:0][7:0] mem [`SOC_BANK_WORDS];

    // byte lanes, read-first
    always_ff @(posedge clk) begin
      for (int i = 0; i < `SOC_STRB_W; i++) begin
        if (bank_wstrb[g][i]) begin
          mem[word_q][i] <= wdata_q[8*i +: 8];
        end
      end
      bank_dout[g] <= mem[word_q];
    end
  end

  always_ff @(posedge clk) begin
    bank_sel_q <= bank_q;
    ram_rdata  <= bank_dout[bank_sel_q];
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
soc_mem_pkg.sv
bus_decoder.sv
banked_ram.sv
led_io.sv
response_mux.sv
soc_mem_top.sv
soc_mem_properties.sv
soc_mem_checker.sv
tb_soc_mem.sv

//--- bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module bus_decoder (
  input  wire logic                   clk,
  input  wire logic                   resetn,
  input  wire logic                   mem_valid,
  input  wire logic [`SOC_ADDR_W-1:0] mem_addr,
  input  wire logic [`SOC_DATA_W-1:0] mem_wdata,
  input  wire logic [`SOC_STRB_W-1:0] mem_wstrb,
  output logic [`SOC_ADDR_W-1:0]      req_addr,
  output logic [`SOC_DATA_W-1:0]      req_wdata,
  output logic [`SOC_STRB_W-1:0]      req_wstrb,
  output logic                        ram_valid,
  output logic                        io_valid,
  output logic                        none_valid,
  output soc_mem_pkg::region_e        req_region
);
  import soc_mem_pkg::*;

  logic [`SOC_PAGE_HI-`SOC_PAGE_LO:0] page;
  region_e                            region;

  assign page = mem_addr[`SOC_PAGE_HI:`SOC_PAGE_LO];

  always_comb begin
    if (page == `SOC_RAM_PAGE) begin
      region = REGION_RAM;
    end else if (page == `SOC_IO_PAGE) begin
      region = REGION_IO;
    end else begin
      region = REGION_NONE;
    end
  end

  // request fields go to every slave, one cycle late
  always_ff @(posedge clk) begin
    req_addr  <= mem_addr;
    req_wdata <= mem_wdata;
    req_wstrb <= mem_wstrb;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ram_valid  <= 1'b0;
      io_valid   <= 1'b0;
      none_valid <= 1'b0;
      req_region <= REGION_NONE;
    end else begin
      ram_valid  <= mem_valid && (region == REGION_RAM);
      io_valid   <= mem_valid && (region == REGION_IO);
      none_valid <= mem_valid && (region == REGION_NONE);
      // idle bus reads as no region
      req_region <= mem_valid ? region : REGION_NONE;
    end
  end

endmodule

`default_nettype wire

//--- led_io.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module led_io (
  input  wire logic                   clk,
  input  wire logic                   resetn,
  input  wire logic                   io_valid,
  input  wire logic [`SOC_ADDR_W-1:0] req_addr,
  input  wire logic [`SOC_DATA_W-1:0] req_wdata,
  input  wire logic [`SOC_STRB_W-1:0] req_wstrb,
  output logic                        io_ready,
  output logic [`SOC_DATA_W-1:0]      io_rdata,
  output logic [`SOC_LED_W-1:0]       led
);
  import soc_mem_pkg::*;

  // word offset inside the IO page
  localparam int OFS_W = `SOC_PAGE_LO - 2;

  logic             valid_q;
  logic             start;
  logic             hit;
  logic [OFS_W-1:0] word_ofs;

  assign start    = io_valid && !valid_q;
  assign word_ofs = req_addr[`SOC_PAGE_LO-1:2];
  assign hit      = (word_ofs == OFS_W'(`SOC_LED_WORD));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q  <= 1'b0;
      io_ready <= 1'b0;
      led      <= '0;
    end else begin
      valid_q  <= io_valid;
      io_ready <= start;
      // only a full-word write updates the LEDs
      if (start && hit && (&req_wstrb)) begin
        led <= req_wdata[`SOC_LED_W-1:0];
      end
    end
  end

  // read returns the value before any write in the same access
  always_ff @(posedge clk) begin
    if (start) begin
      io_rdata <= hit ? {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, led} : '0;
    end
  end

endmodule

`default_nettype wire

//--- response_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module response_mux (
  input  wire logic                   clk,
  input  wire logic                   resetn,
  input  wire soc_mem_pkg::region_e   req_region,
  input  wire logic                   none_valid,
  input  wire logic                   ram_ready,
  input  wire logic                   io_ready,
  input  wire logic [`SOC_DATA_W-1:0] ram_rdata,
  input  wire logic [`SOC_DATA_W-1:0] io_rdata,
  output logic                        mem_ready,
  output logic [`SOC_DATA_W-1:0]      mem_rdata
);
  import soc_mem_pkg::*;

  logic                   none_q;
  logic                   none_ready;
  logic                   sel_ready;
  logic [`SOC_DATA_W-1:0] sel_data;

  // reply of the region in flight
  always_comb begin
    case (req_region)
      REGION_RAM: begin
        sel_ready = ram_ready;
        sel_data  = ram_rdata;
      end
      REGION_IO: begin
        sel_ready = io_ready;
        sel_data  = io_rdata;
      end
      default: begin
        sel_ready = none_ready;
        sel_data  = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      none_q     <= 1'b0;
      none_ready <= 1'b0;
      mem_ready  <= 1'b0;
    end else begin
      none_q <= none_valid;
      // unmapped access answers by itself, so the bus never hangs
      none_ready <= none_valid && !none_q;
      mem_ready  <= sel_ready;
    end
  end

  always_ff @(posedge clk) begin
    mem_rdata <= sel_ready ? sel_data : '0;
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_soc_mem -f build.f -o tb_soc_mem

./obj_dir/tb_soc_mem | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failure"

//--- soc_mem_cfg.svh
`ifndef SOC_MEM_CFG_SVH
`define SOC_MEM_CFG_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_STRB_W 4

// upper address bits that pick a region
`define SOC_PAGE_HI 31
`define SOC_PAGE_LO 16
`define SOC_RAM_PAGE 16'h0001
`define SOC_IO_PAGE 16'h8001

// data RAM, 4 banks of 16 KB
`define SOC_RAM_BANKS 4
`define SOC_BANK_WORDS 4096
`define SOC_BANK_SEL_HI 15
`define SOC_BANK_SEL_LO 14

// LED register in the IO page
`define SOC_LED_W 4
`define SOC_LED_WORD 'h10

`endif

//--- soc_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module soc_mem_checker (
  input  wire logic                   clk,
  input  wire logic                   resetn,
  input  wire logic [`SOC_ADDR_W-1:0] mem_addr,
  input  wire logic [`SOC_DATA_W-1:0] mem_wdata,
  input  wire logic [`SOC_STRB_W-1:0] mem_wstrb,
  input  wire logic                   mem_ready,
  input  wire logic [`SOC_DATA_W-1:0] mem_rdata,
  input  wire logic [`SOC_LED_W-1:0]  led,
  input  wire logic                   test_done,
  input  wire logic [31:0]            test_num,
  input  wire logic [`SOC_DATA_W-1:0] exp_rdata,
  input  wire logic [`SOC_LED_W-1:0]  exp_led,
  output logic [31:0]                 pass_count,
  output logic [31:0]                 fail_count
);

  // reference model, one entry per RAM word
  logic [31:0]           ram_model [1 << 14];
  logic [`SOC_LED_W-1:0] led_model = '0;
  logic                  resetn_q = 1'b0;
  int                    test_errs = 0;
  int                    passes = 0;
  int                    fails = 0;

  assign pass_count = passes;
  assign fail_count = fails;

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
      test_errs++;
    end
  endtask

  task automatic report_test(input logic [31:0] num);
    if (test_errs == 0) begin
      $display("test %0d passed", num);
      passes++;
    end else begin
      $display("test %0d failed with %0d errors", num, test_errs);
      fails++;
    end
    test_errs = 0;
  endtask

  // apply one finished access to the model and check read data
  task automatic model_access();
    logic [15:0] page;
    logic [31:0] expected;
    page = mem_addr[31:16];
    expected = '0;
    if (page == `SOC_RAM_PAGE) begin
      if (mem_wstrb != '0) begin
        ram_model[mem_addr[15:2]] = merge_bytes(ram_model[mem_addr[15:2]], mem_wdata, mem_wstrb);
      end else begin
        expected = ram_model[mem_addr[15:2]];
      end
    end else if (page == `SOC_IO_PAGE && mem_addr[15:2] == 14'(`SOC_LED_WORD)) begin
      if (mem_wstrb == 4'hf) begin
        led_model = mem_wdata[`SOC_LED_W-1:0];
      end
      expected = 32'(led_model);
    end
    if (mem_wstrb == '0) begin
      compare_value("mem_rdata", exp_rdata, mem_rdata);
      compare_value("mem_rdata(model)", expected, mem_rdata);
    end
  endtask

  always @(posedge clk) begin
    resetn_q <= resetn;
    if (resetn && !resetn_q) begin
      compare_value("mem_ready", 32'd0, 32'(mem_ready));
      compare_value("led", 32'd0, 32'(led));
      report_test(32'd0);
    end
    if (resetn && mem_ready) begin
      model_access();
    end
    if (resetn && test_done) begin
      compare_value("led", 32'(exp_led), 32'(led));
      compare_value("led(model)", 32'(led_model), 32'(led));
      report_test(test_num);
    end
  end

endmodule

`default_nettype wire

//--- soc_mem_pkg.sv
`default_nettype none

package soc_mem_pkg;

  // region picked by the decoder for the request in flight
  typedef enum logic [1:0] {
    REGION_NONE = 2'd0,
    REGION_RAM  = 2'd1,
    REGION_IO   = 2'd2
  } region_e;

  // data RAM access sequence
  // write: IDLE -> WRITE -> IDLE
  // read:  IDLE -> READ -> DONE -> IDLE
  typedef enum logic [1:0] {
    RAM_IDLE  = 2'd0,
    RAM_WRITE = 2'd1,
    RAM_READ  = 2'd2,
    RAM_DONE  = 2'd3
  } ram_state_e;

endpackage

`default_nettype wire

//--- soc_mem_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module soc_mem_properties (
  input wire logic                  clk,
  input wire logic                  resetn,
  input wire logic                  mem_valid,
  input wire logic                  mem_ready,
  input wire logic [`SOC_LED_W-1:0] led
);

  // reply is a single-cycle pulse
  ready_pulse: assert property (@(posedge clk) disable iff (!resetn) mem_ready |=> !mem_ready)
    else $error("mem_ready stayed high for two cycles");

  // a reply needs a request that was already held
  ready_after_valid: assert property (@(posedge clk) disable iff (!resetn)
    mem_ready |-> (mem_valid && $past(mem_valid)))
    else $error("mem_ready without a held mem_valid");

  // first reset edge loads the register, so look one cycle later
  led_in_reset: assert property (@(posedge clk) !resetn |=> (resetn || (led == '0)))
    else $error("led not cleared while resetn is low");

endmodule

`default_nettype wire

//--- soc_mem_tests.txt
// op(1=write 0=read) addr data strb exp_rdata exp_led, all hex
// op ff ends the list
1 00010010 deadbeef f 00000000 0
0 00010010 00000000 0 deadbeef 0
1 00010010 000000a5 1 00000000 0
1 00010010 12340000 c 00000000 0
0 00010010 00000000 0 1234bea5 0
1 00010040 11111111 f 00000000 0
1 00014040 22222222 f 00000000 0
1 00018040 33333333 f 00000000 0
1 0001c040 44444444 f 00000000 0
0 00010040 00000000 0 11111111 0
0 00014040 00000000 0 22222222 0
0 00018040 00000000 0 33333333 0
0 0001c040 00000000 0 44444444 0
1 00018040 0000ee00 2 00000000 0
0 00018040 00000000 0 3333ee33 0
1 80010040 0000000a f 00000000 a
0 80010040 00000000 0 0000000a a
1 80010040 00000005 3 00000000 a
0 80010040 00000000 0 0000000a a
1 80010044 00000003 f 00000000 a
0 80010044 00000000 0 00000000 a
0 00050000 00000000 0 00000000 a
1 00050000 ffffffff f 00000000 a
0 00010010 00000000 0 1234bea5 a
0 00014040 00000000 0 22222222 a
1 80010040 fffffff5 f 00000000 5
0 80010040 00000000 0 00000005 5
ff 0 0 0 0 0

//--- soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module soc_mem_top (
  input  wire logic                   clk,
  input  wire logic                   resetn,
  input  wire logic                   mem_valid,
  input  wire logic [`SOC_ADDR_W-1:0] mem_addr,
  input  wire logic [`SOC_DATA_W-1:0] mem_wdata,
  input  wire logic [`SOC_STRB_W-1:0] mem_wstrb,
  output logic                        mem_ready,
  output logic [`SOC_DATA_W-1:0]      mem_rdata,
  output logic [`SOC_LED_W-1:0]       led
);
  import soc_mem_pkg::*;

  logic [`SOC_ADDR_W-1:0] req_addr;
  logic [`SOC_DATA_W-1:0] req_wdata;
  logic [`SOC_STRB_W-1:0] req_wstrb;
  logic                   ram_valid;
  logic                   io_valid;
  logic                   none_valid;
  region_e                req_region;
  logic                   ram_ready;
  logic                   io_ready;
  logic [`SOC_DATA_W-1:0] ram_rdata;
  logic [`SOC_DATA_W-1:0] io_rdata;

  bus_decoder i_decoder (
    .clk        (clk),
    .resetn     (resetn),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_wstrb  (req_wstrb),
    .ram_valid  (ram_valid),
    .io_valid   (io_valid),
    .none_valid (none_valid),
    .req_region (req_region)
  );

  banked_ram i_ram (
    .clk       (clk),
    .resetn    (resetn),
    .ram_valid (ram_valid),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb),
    .ram_ready (ram_ready),
    .ram_rdata (ram_rdata)
  );

  led_io i_led (
    .clk       (clk),
    .resetn    (resetn),
    .io_valid  (io_valid),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .req_wstrb (req_wstrb),
    .io_ready  (io_ready),
    .io_rdata  (io_rdata),
    .led       (led)
  );

  response_mux i_resp (
    .clk        (clk),
    .resetn     (resetn),
    .req_region (req_region),
    .none_valid (none_valid),
    .ram_ready  (ram_ready),
    .io_ready   (io_ready),
    .ram_rdata  (ram_rdata),
    .io_rdata   (io_rdata),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata)
  );

endmodule

`default_nettype wire

//--- tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_mem_cfg.svh"

module tb_soc_mem;

  localparam int MAX_TESTS = 64;
  localparam int TIMEOUT_CYCLES = 20;

  logic                   clk;
  logic                   resetn;
  logic                   mem_valid;
  logic [`SOC_ADDR_W-1:0] mem_addr;
  logic [`SOC_DATA_W-1:0] mem_wdata;
  logic [`SOC_STRB_W-1:0] mem_wstrb;
  logic                   mem_ready;
  logic [`SOC_DATA_W-1:0] mem_rdata;
  logic [`SOC_LED_W-1:0]  led;
  logic                   test_done;
  logic [31:0]            test_num;
  logic [`SOC_DATA_W-1:0] exp_rdata;
  logic [`SOC_LED_W-1:0]  exp_led;
  logic [31:0]            pass_count;
  logic [31:0]            fail_count;
  // six fields per test line
  logic [31:0]            vectors [6*MAX_TESTS];

  soc_mem_top i_dut (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .led       (led)
  );

  soc_mem_checker i_checker (
    .clk        (clk),
    .resetn     (resetn),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata),
    .led        (led),
    .test_done  (test_done),
    .test_num   (test_num),
    .exp_rdata  (exp_rdata),
    .exp_led    (exp_led),
    .pass_count (pass_count),
    .fail_count (fail_count)
  );

  bind soc_mem_top soc_mem_properties i_props (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .led       (led)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    int t;
    int cycles;
    bit timed_out;
    resetn    = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    test_done = 1'b0;
    test_num  = '0;
    exp_rdata = '0;
    exp_led   = '0;
    timed_out = 1'b0;
    $readmemh("soc_mem_tests.txt", vectors);
    repeat (5) @(posedge clk);
    resetn <= 1'b1;
    t = 0;
    while (!timed_out && t < MAX_TESTS && vectors[6*t] != 32'hff) begin
      @(posedge clk);
      mem_valid <= 1'b1;
      mem_addr  <= vectors[6*t+1];
      mem_wdata <= vectors[6*t+2];
      // a read never carries strobes
      mem_wstrb <= (vectors[6*t] == 32'd1) ? vectors[6*t+3][3:0] : '0;
      exp_rdata <= vectors[6*t+4];
      exp_led   <= vectors[6*t+5][`SOC_LED_W-1:0];
      test_num  <= t + 1;
      cycles = 0;
      do begin
        @(posedge clk);
        cycles++;
      end while (!mem_ready && cycles < TIMEOUT_CYCLES);
      mem_valid <= 1'b0;
      if (!mem_ready) begin
        $display("test %0d timed out: no mem_ready within %0d cycles", t + 1, TIMEOUT_CYCLES);
        timed_out = 1'b1;
      end else begin
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
      end
      t++;
    end
    // let the checker settle its counts
    @(posedge clk);
    $display("tests: %0d passed, %0d failed", pass_count, fail_count);
    if (!timed_out && fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
